//--- logic/link_pkg.sv
`default_nettype none

package link_pkg;

    ////////////////////
    // link word format
    localparam int word_width = 32;                  // one word per link beat
    typedef logic [word_width-1:0] word_t;

    ////////////////////
    // command codes
    localparam int opcode_width = 5;                 // low bits of the command word
    typedef enum logic [opcode_width-1:0] {
        cc_loopback = 5'd1,                          // echo the rest of the frame
        cc_rd_reg   = 5'd2,                          // reg number follows
        cc_wr_reg   = 5'd3                           // reg number, then data
    } opcode_t;

    ////////////////////
    // response path
    typedef struct packed {
        logic  last;                                 // final word of the response
        word_t data;
    } resp_word_t;

    localparam int resp_fifo_depth     = 16;         // power of two, pointers wrap freely
    localparam int resp_fifo_ptr_width = $clog2(resp_fifo_depth);

endpackage

`default_nettype wire

//--- logic/reg_map_pkg.sv
`default_nettype none

package reg_map_pkg;

    ////////////////////
    // register map
    localparam int num_regs = 8;                          // 0 and 1 read-only, 2..7 r/w
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t reg_chan_addr = 3'd0;            // corrected channel jumpers
    localparam reg_idx_t reg_cmd_count = 3'd1;            // commands accepted since reset

    // board jumpers for channel 3 are strapped as 110
    localparam logic [2:0] jumper_miswired = 3'd6;
    localparam logic [2:0] jumper_fixed    = 3'd3;

    ////////////////////
    // bank access
    typedef struct packed {
        logic             rd_en;                          // one-cycle read strobe
        logic             wr_en;                          // one-cycle write strobe
        link_pkg::word_t  reg_num;                        // full word, range checked in bank
        link_pkg::word_t  wr_data;
    } reg_req_t;

    typedef struct packed {
        logic             ack;                            // one cycle after the strobe
        logic             illegal;                        // reg number out of range
        link_pkg::word_t  rd_data;
    } reg_rsp_t;

endpackage

`default_nettype wire

//--- logic/cmd_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_receiver (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire link_pkg::word_t       rx_data,
    input  wire logic                  rx_tvalid,
    input  wire logic                  rx_tlast,
    input  wire logic                  full,          // response fifo cannot take a word
    input  wire reg_map_pkg::reg_rsp_t reg_rsp,
    output logic                       rx_tready,
    output logic                       push,
    output link_pkg::resp_word_t       push_word,
    output reg_map_pkg::reg_req_t      reg_req,
    output logic                       cmd_seen,      // one pulse per accepted command word
    output logic                       cmd_idle
);
    import link_pkg::*;

    typedef enum logic [3:0] {
        idle, get_cmd, push_csn, push_cmd, echo, get_reg, get_data, reg_wait, push_result
    } state_t;

    state_t  state;
    word_t   csn;                 // serial number of the current frame
    word_t   cmd_word;
    word_t   rd_data;             // captured on ack
    logic    cmd_last;            // command word closed the frame
    logic    illegal;             // bank rejected the reg number
    logic    discard;             // swallow rest of a frame with unknown opcode
    opcode_t op;
    logic    known;
    logic    receiving;
    logic    rx_take;

    assign op        = opcode_t'(cmd_word[opcode_width-1:0]);
    assign known     = op inside {cc_loopback, cc_rd_reg, cc_wr_reg};
    assign receiving = state inside {idle, get_cmd, echo, get_reg, get_data};
    assign rx_tready = receiving && rx_tvalid && !full;   // every accepted word may push
    assign rx_take   = rx_tvalid && rx_tready;
    assign cmd_seen  = (state == get_cmd) && rx_take;
    assign cmd_idle  = (state == idle);

    ////////////////////
    // response word mux
    always_comb begin
        push      = 1'b0;
        push_word = '{last: 1'b0, data: csn};
        case (state)
            push_csn: push = !full;
            push_cmd: begin
                push = !full;
                if (!known || illegal) begin
                    push_word = '{last: 1'b1, data: ~cmd_word};   // failure response
                end else begin
                    push_word.data = cmd_word;
                    push_word.last = (op == cc_wr_reg) || (op == cc_loopback && cmd_last);
                end
            end
            push_result: begin
                push      = !full;
                push_word = '{last: 1'b1, data: rd_data};
            end
            echo: begin
                push      = rx_take && !discard;
                push_word = '{last: rx_tlast, data: rx_data};     // loopback payload
            end
            default: ;
        endcase
    end

    ////////////////////
    // frame sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            reg_req  <= '0;
            cmd_last <= 1'b0;
            illegal  <= 1'b0;
            discard  <= 1'b0;
        end else begin
            reg_req.rd_en <= 1'b0;                        // strobes last one cycle
            reg_req.wr_en <= 1'b0;
            case (state)
                idle: if (rx_take) state <= get_cmd;
                get_cmd: if (rx_take) begin
                    cmd_last <= rx_tlast;
                    illegal  <= 1'b0;
                    discard  <= 1'b0;
                    state    <= push_csn;
                end
                push_csn: if (!full) begin
                    if (known && op != cc_loopback)
                        state <= get_reg;                 // cmd word waits for the ack
                    else
                        state <= push_cmd;
                end
                push_cmd: if (!full) begin
                    if (known && (illegal || op == cc_wr_reg)) begin
                        state <= idle;
                    end else if (known && op == cc_rd_reg) begin
                        state <= push_result;
                    end else begin
                        discard <= !known;
                        state   <= cmd_last ? idle : echo;
                    end
                end
                echo: if (rx_take && rx_tlast) state <= idle;
                get_reg: if (rx_take) begin
                    reg_req.reg_num <= rx_data;
                    if (op == cc_rd_reg) begin
                        reg_req.rd_en <= 1'b1;
                        state         <= reg_wait;
                    end else begin
                        state <= get_data;
                    end
                end
                get_data: if (rx_take) begin
                    reg_req.wr_data <= rx_data;
                    reg_req.wr_en   <= 1'b1;
                    state           <= reg_wait;
                end
                reg_wait: if (reg_rsp.ack) begin
                    illegal <= reg_rsp.illegal;
                    state   <= push_cmd;
                end
                push_result: if (!full) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    ////////////////////
    // frame payload latches
    always_ff @(posedge clk) begin
        if (state == idle && rx_take)     csn      <= rx_data;
        if (state == get_cmd && rx_take)  cmd_word <= rx_data;
        if (state == reg_wait && reg_rsp.ack) rd_data <= reg_rsp.rd_data;
    end

endmodule

`default_nettype wire

//--- logic/register_bank.sv
`timescale 1ns/100ps
`default_nettype none

module register_bank (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire reg_map_pkg::reg_req_t reg_req,
    input  wire logic                  cmd_seen,
    input  wire logic [2:0]            ch_addr,       // board jumpers, static
    output reg_map_pkg::reg_rsp_t      reg_rsp
);
    import link_pkg::*;
    import reg_map_pkg::*;

    word_t      rw_regs [reg_cmd_count+1:num_regs-1];  // general purpose 2..7
    word_t      cmd_count;
    word_t      rd_word;
    logic [2:0] ch_fixed;                              // corrected jumpers
    reg_idx_t   idx;
    logic       legal;

    assign idx   = reg_req.reg_num[$bits(reg_idx_t)-1:0];
    assign legal = reg_req.reg_num < word_t'(num_regs);  // upper bits must be zero too

    // channel 3 is strapped wrong on the board
    always_ff @(posedge clk) begin
        ch_fixed <= (ch_addr == jumper_miswired) ? jumper_fixed : ch_addr;
    end

    always_comb begin
        case (idx)
            reg_chan_addr: rd_word = word_t'(ch_fixed);
            reg_cmd_count: rd_word = cmd_count;
            default:       rd_word = rw_regs[idx];
        endcase
    end

    ////////////////////
    // storage and response
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_count <= '0;
            reg_rsp   <= '0;
            for (int i = reg_cmd_count + 1; i < num_regs; i++)
                rw_regs[i] <= '0;
        end else begin
            if (cmd_seen) cmd_count <= cmd_count + 1'b1;
            if (reg_req.wr_en && legal && idx > reg_cmd_count)  // 0 and 1 ignore writes
                rw_regs[idx] <= reg_req.wr_data;
            reg_rsp.ack     <= reg_req.rd_en || reg_req.wr_en;
            reg_rsp.illegal <= !legal;
            reg_rsp.rd_data <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- logic/resp_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module resp_fifo (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 push,
    input  wire link_pkg::resp_word_t push_word,
    input  wire logic                 pop,
    output link_pkg::resp_word_t      head,       // oldest entry, valid when not empty
    output logic                      empty,
    output logic                      full
);
    import link_pkg::*;

    resp_word_t                     mem [resp_fifo_depth];
    logic [resp_fifo_ptr_width-1:0] wr_ptr;
    logic [resp_fifo_ptr_width-1:0] rd_ptr;
    logic [resp_fifo_ptr_width:0]   count;        // one extra bit to hold depth

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == resp_fifo_depth[resp_fifo_ptr_width:0]);

    ////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                        // both or neither, no change
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_word;
    end

endmodule

`default_nettype wire

//--- logic/tx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module tx_framer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire link_pkg::resp_word_t head,
    input  wire logic                 empty,
    input  wire logic                 tx_tready,
    output logic                      pop,
    output link_pkg::word_t           tx_data,
    output logic                      tx_tvalid,
    output logic                      tx_tlast
);
    logic load;                                    // output register free this cycle

    assign load = !tx_tvalid || tx_tready;         // empty or being taken
    assign pop  = load && !empty;

    ////////////////////
    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_tvalid <= 1'b0;
            tx_tlast  <= 1'b0;
        end else if (load) begin
            tx_tvalid <= !empty;                   // refill without a gap
            tx_tlast  <= !empty && head.last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) tx_data <= head.data;             // held while stalled
    end

endmodule

`default_nettype wire

//--- logic/command_top.sv
`timescale 1ns/100ps
`default_nettype none

module command_top (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire link_pkg::word_t rx_data,
    input  wire logic            rx_tvalid,
    input  wire logic            rx_tlast,
    output logic                 rx_tready,
    output link_pkg::word_t      tx_data,
    output logic                 tx_tvalid,
    output logic                 tx_tlast,
    input  wire logic            tx_tready,
    input  wire logic [2:0]      ch_addr,     // channel jumpers
    output logic                 cmd_idle
);
    import link_pkg::*;
    import reg_map_pkg::*;

    reg_req_t   reg_req;
    reg_rsp_t   reg_rsp;
    resp_word_t push_word;
    resp_word_t head;
    logic       push, pop, full, empty;
    logic       cmd_seen;

    ////////////////////
    // producer and bank
    cmd_receiver cmd_receiver (
        .clk, .reset,
        .rx_data, .rx_tvalid, .rx_tlast, .rx_tready,
        .full, .push, .push_word,                 // into the response fifo
        .reg_req, .reg_rsp, .cmd_seen, .cmd_idle
    );

    register_bank register_bank (
        .clk, .reset, .reg_req, .cmd_seen, .ch_addr, .reg_rsp
    );

    ////////////////////
    // buffer and consumer
    resp_fifo resp_fifo (
        .clk, .reset, .push, .push_word, .pop, .head, .empty, .full
    );

    tx_framer tx_framer (
        .clk, .reset, .head, .empty, .tx_tready,
        .pop, .tx_data, .tx_tvalid, .tx_tlast
    );

endmodule

`default_nettype wire

//--- testbench/tb_command_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_command_top;
    import link_pkg::*;
    import reg_map_pkg::*;

    logic        clk;
    logic        reset;
    word_t       rx_data;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tready;
    word_t       tx_data;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;
    logic [2:0]  ch_addr;
    logic        cmd_idle;

    logic [31:0] lfsr = 32'h75bec35e;             // fixed seed
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cmds_sent = 0;                    // command words taken since reset
    logic        timed_out = 1'b0;

    command_top UUT (
        .clk, .reset,
        .rx_data, .rx_tvalid, .rx_tlast, .rx_tready,
        .tx_data, .tx_tvalid, .tx_tlast, .tx_tready,
        .ch_addr, .cmd_idle
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                         // 40 ns period

    ////////////////////
    // stimulus helpers
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int i = 0; i < word_width; i++)
            w = {w[word_width-2:0], lfsr_bit()};   // one step per bit
        return w;
    endfunction

    function automatic word_t make_cmd(input logic [opcode_width-1:0] op);
        word_t w;
        w = '0;
        for (int i = 0; i < word_width - opcode_width; i++)
            w = {w[word_width-2:0], lfsr_bit()};   // junk in the upper bits
        return {w[word_width-opcode_width-1:0], op};
    endfunction

    ////////////////////
    // link tasks
    task automatic send_frame(input word_t words[$]);
        int   waited;
        logic taken;
        @(posedge clk);
        for (int i = 0; i < words.size() && !timed_out; i++) begin
            rx_data   <= words[i];
            rx_tvalid <= 1'b1;
            rx_tlast  <= (i == words.size() - 1);
            taken  = 1'b0;
            waited = 0;
            while (!taken && !timed_out) begin
                @(negedge clk);
                taken = rx_tready;                 // transfer on the coming edge
                @(posedge clk);
                waited++;
                if (!taken && waited > 1000) begin
                    timed_out = 1'b1;
                    $display("timeout at %0t: DUT never accepted rx word %0d", $time, i);
                end
            end
            if (taken && i == 1) cmds_sent++;      // second word is the command
        end
        rx_tvalid <= 1'b0;
        rx_tlast  <= 1'b0;
    endtask

    task automatic collect_response(output word_t got[$], input logic stall);
        int   waited;
        logic done;
        got    = {};
        waited = 0;
        done   = 1'b0;
        while (!done && !timed_out) begin
            @(posedge clk);
            tx_tready <= stall ? lfsr_bit() : 1'b1;   // random back-pressure
            @(negedge clk);
            if (tx_tvalid && tx_tready) begin
                got.push_back(tx_data);
                done = tx_tlast;
            end
            waited++;                              // whole response must fit the window
            if (!done && waited > 1000) begin
                timed_out = 1'b1;
                $display("timeout at %0t: response from the DUT never ended", $time);
            end
        end
    endtask

    task automatic compare_response(input string name, input word_t exp[$], input word_t got[$]);
        int n;
        n = (got.size() < exp.size()) ? got.size() : exp.size();
        checks++;
        assert (got.size() == exp.size()) else begin
            errors++;
            $display("ERROR %0t: %s returned %0d words, expected %0d",
                     $time, name, got.size(), exp.size());
        end
        for (int i = 0; i < n; i++) begin
            checks++;
            assert (got[i] == exp[i]) else begin
                errors++;
                $display("ERROR %0t: %s word %0d is %h, expected %h",
                         $time, name, i, got[i], exp[i]);
            end
        end
    endtask

    task automatic run_frame(input string name, input word_t words[$], input word_t exp[$],
                             input logic stall);
        word_t got[$];
        if (timed_out) return;                     // link is stuck, skip
        fork
            send_frame(words);
            collect_response(got, stall);
        join
        if (!timed_out) compare_response(name, exp, got);
    endtask

    // data is the write value for writes and the expected value for reads
    task automatic reg_frame(input string name, input logic [opcode_width-1:0] op,
                             input word_t reg_num, input word_t data, input logic ok);
        word_t words[$];
        word_t exp[$];
        word_t cmd;
        cmd = make_cmd(op);
        words.push_back(random_word());            // serial number
        words.push_back(cmd);
        words.push_back(reg_num);
        if (op == cc_wr_reg) words.push_back(data);
        exp.push_back(words[0]);
        exp.push_back(ok ? cmd : ~cmd);            // inverse on failure
        if (ok && op == cc_rd_reg) exp.push_back(data);
        run_frame(name, words, exp, 1'b0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %s %s", name, (errors == errs_before && !timed_out) ? "ok" : "failed");
    endtask

    ////////////////////
    // directed tests
    task automatic reset_state_test();
        int errs;
        errs = errors;
        @(negedge clk);
        checks++;
        assert (!rx_tready && !tx_tvalid && !tx_tlast && cmd_idle) else begin
            errors++;
            $display("ERROR %0t: after reset rx_tready=%b tx_tvalid=%b tx_tlast=%b cmd_idle=%b",
                     $time, rx_tready, tx_tvalid, tx_tlast, cmd_idle);
        end
        finish_test("reset state", errs);
    endtask

    task automatic loopback_test();
        word_t words[$];
        int    errs;
        errs = errors;
        words.push_back(random_word());
        words.push_back(make_cmd(cc_loopback));
        for (int i = 0; i < 5; i++) words.push_back(random_word());
        run_frame("loopback", words, words, 1'b1);   // whole frame echoes back
        finish_test("loopback", errs);
    endtask

    task automatic write_read_test();
        word_t value;
        int    errs;
        errs  = errors;
        value = random_word();
        reg_frame("write reg 5", cc_wr_reg, 32'd5, value, 1'b1);
        reg_frame("read reg 5", cc_rd_reg, 32'd5, value, 1'b1);
        finish_test("write then read", errs);
    endtask

    task automatic illegal_reg_test();
        int errs;
        errs = errors;
        reg_frame("read reg 9", cc_rd_reg, 32'd9, '0, 1'b0);
        reg_frame("write reg 9", cc_wr_reg, 32'd9, random_word(), 1'b0);
        reg_frame("write reg 0", cc_wr_reg, word_t'(reg_chan_addr), random_word(), 1'b1);
        reg_frame("read reg 0", cc_rd_reg, word_t'(reg_chan_addr),
                  word_t'(ch_addr), 1'b1);   // jumper 5 reads as itself, write had no effect
        finish_test("illegal register", errs);
    endtask

    task automatic unknown_opcode_test();
        word_t words[$];
        word_t exp[$];
        int    errs;
        errs = errors;
        words.push_back(random_word());
        words.push_back(make_cmd(5'd17));
        words.push_back(random_word());            // swallowed by the DUT
        exp.push_back(words[0]);
        exp.push_back(~words[1]);
        run_frame("opcode 17", words, exp, 1'b0);
        finish_test("unknown opcode", errs);
    endtask

    task automatic jumper_counter_test();
        int errs;
        errs = errors;
        @(posedge clk);
        ch_addr <= 3'd6;                           // strapping of channel 3
        reg_frame("read jumpers", cc_rd_reg, word_t'(reg_chan_addr), 32'd3, 1'b1);
        reg_frame("read cmd count", cc_rd_reg, word_t'(reg_cmd_count),
                  word_t'(cmds_sent + 1), 1'b1);   // counts the read itself
        finish_test("jumpers, counter", errs);
    endtask

    ////////////////////
    // main sequence
    initial begin
        reset     = 1'b1;
        rx_data   = '0;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        tx_tready = 1'b0;
        ch_addr   = 3'd5;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reset_state_test();
        loopback_test();
        write_read_test();
        illegal_reg_test();
        unknown_opcode_test();
        jumper_counter_test();
        $display("tests %0d, checks %0d, errors %0d, timed out %0d",
                 tests, checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/link_pkg.sv
logic/reg_map_pkg.sv
logic/cmd_receiver.sv
logic/register_bank.sv
logic/resp_fifo.sv
logic/tx_framer.sv
logic/command_top.sv
testbench/tb_command_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_command_top -f flist.f -Mdir obj_dir
out=$(./obj_dir/Vtb_command_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
